//--- hw/rv_isa_pkg.sv
// RV32 opcode, funct3 and funct7 encodings and instruction field positions
`default_nettype none

package rv_isa_pkg;

	// Major opcodes
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

	// funct3 codes of the ALU subset, MUL shares F3_ADD
	localparam logic [2:0] F3_ADD = 3'b000;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_OR  = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	// funct7 codes
	localparam logic [6:0] F7_BASE   = 7'b0000000;
	localparam logic [6:0] F7_SUB    = 7'b0100000;
	localparam logic [6:0] F7_MULDIV = 7'b0000001;

	// Field positions, lsb of each field
	localparam int OPC_LSB = 0;
	localparam int RD_LSB  = 7;
	localparam int F3_LSB  = 12;
	localparam int RS1_LSB = 15;
	localparam int RS2_LSB = 20;
	localparam int IMM_LSB = 20;
	localparam int F7_LSB  = 25;

endpackage

`default_nettype wire

//--- hw/exe_pkg.sv
// Data width, register index, ALU operation and stage payload types
`default_nettype none

package exe_pkg;

	localparam int XLEN = 32;

	typedef logic [4:0] reg_addr_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT
	} alu_op_e;

	typedef struct packed {
		logic            valid;
		logic [31:0]     instr;
	} issue_t;

	// Execute latch contents, operands already forwarded
	typedef struct packed {
		logic            valid;
		reg_addr_t       rd;
		logic            we;
		logic            mul;
		alu_op_e         alu_op;
		logic [XLEN-1:0] op_a;
		logic [XLEN-1:0] op_b;
		logic [XLEN-1:0] imm;
		logic            use_imm;
	} exe_ctrl_t;

	typedef struct packed {
		logic            valid;
		reg_addr_t       rd;
		logic [XLEN-1:0] value;
	} mult_stage_t;

	typedef struct packed {
		logic            valid;
		reg_addr_t       rd;
		logic [XLEN-1:0] data;
	} retire_t;

endpackage

`default_nettype wire

//--- hw/pipe_reg.sv
// Generic pipeline stage register with hold, typed on its payload
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
	parameter type payload_t = logic [31:0]
) (
	input  wire      clk_i,
	input  wire      arst_n_i,
	input  wire      hold_i,
	input  payload_t d_i,
	output payload_t q_o
);

	// Valid bit lives inside the payload, so the whole word is cleared
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			q_o <= '0;
		end else if (!hold_i) begin
			q_o <= d_i;
		end
	end

	a_q_known: assert property (
		@(posedge clk_i) disable iff (!arst_n_i) !$isunknown(q_o)
	);

endmodule

`default_nettype wire

//--- hw/decoder.sv
// Instruction decoder for the RV32 ALU and MUL subset
`timescale 1ns/1ps
`default_nettype none

module decoder
	import rv_isa_pkg::*;
	import exe_pkg::*;
(
	input  wire  [31:0]     instr_i,
	output reg_addr_t       rs1_o,
	output reg_addr_t       rs2_o,
	output reg_addr_t       rd_o,
	output logic            we_o,
	output logic            mul_o,
	output logic            use_imm_o,
	output logic [XLEN-1:0] imm_o,
	output alu_op_e         alu_op_o,
	output logic            uses_rs2_o
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       supported;

	assign opcode = instr_i[OPC_LSB +: 7];
	assign funct3 = instr_i[F3_LSB +: 3];
	assign funct7 = instr_i[F7_LSB +: 7];
	assign rs1_o  = instr_i[RS1_LSB +: 5];
	assign rs2_o  = instr_i[RS2_LSB +: 5];
	assign rd_o   = instr_i[RD_LSB +: 5];
	assign imm_o  = {{(XLEN-12){instr_i[31]}}, instr_i[IMM_LSB +: 12]};

	always_comb begin
		supported  = 1'b0;
		mul_o      = 1'b0;
		use_imm_o  = 1'b0;
		uses_rs2_o = 1'b0;
		alu_op_o   = ALU_ADD;
		if (opcode == OPC_OP) begin
			uses_rs2_o = 1'b1;
			if (funct7 == F7_MULDIV && funct3 == F3_ADD) begin
				supported = 1'b1;
				mul_o     = 1'b1;
			end else if (funct7 == F7_SUB && funct3 == F3_ADD) begin
				supported = 1'b1;
				alu_op_o  = ALU_SUB;
			end else if (funct7 == F7_BASE) begin
				supported = 1'b1;
				case (funct3)
					F3_ADD:  alu_op_o = ALU_ADD;
					F3_SLT:  alu_op_o = ALU_SLT;
					F3_XOR:  alu_op_o = ALU_XOR;
					F3_OR:   alu_op_o = ALU_OR;
					F3_AND:  alu_op_o = ALU_AND;
					default: supported = 1'b0;
				endcase
			end
		end else if (opcode == OPC_OP_IMM) begin
			use_imm_o = 1'b1;
			supported = 1'b1;
			// No SLTI in the subset
			case (funct3)
				F3_ADD:  alu_op_o = ALU_ADD;
				F3_XOR:  alu_op_o = ALU_XOR;
				F3_OR:   alu_op_o = ALU_OR;
				F3_AND:  alu_op_o = ALU_AND;
				default: supported = 1'b0;
			endcase
		end
		if (!supported) begin
			mul_o      = 1'b0;
			uses_rs2_o = 1'b0;
		end
	end

	// Unsupported words and x0 targets become NOPs
	assign we_o = supported && (rd_o != '0);

endmodule

`default_nettype wire

//--- hw/int_registers.sv
// Integer register file, two read ports and one write port
`timescale 1ns/1ps
`default_nettype none

module int_registers
	import exe_pkg::*;
(
	input  wire             clk_i,
	input  wire             arst_n_i,
	input  reg_addr_t       rs1_i,
	input  reg_addr_t       rs2_i,
	input  reg_addr_t       rd_i,
	input  wire             we_i,
	input  wire  [XLEN-1:0] wdata_i,
	output logic [XLEN-1:0] rdata1_o,
	output logic [XLEN-1:0] rdata2_o
);

	logic [XLEN-1:0] regs [32];

	// x0 is never written, so it stays at its reset value
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && rd_i != '0) begin
			regs[rd_i] <= wdata_i;
		end
	end

	assign rdata1_o = regs[rs1_i];
	assign rdata2_o = regs[rs2_i];

	a_no_x0_write: assert property (
		@(posedge clk_i) disable iff (!arst_n_i) !(we_i && rd_i == '0)
	);

endmodule

`default_nettype wire

//--- hw/int_alu.sv
// Single-cycle integer ALU
`timescale 1ns/1ps
`default_nettype none

module int_alu
	import exe_pkg::*;
(
	input  alu_op_e         op_i,
	input  wire  [XLEN-1:0] a_i,
	input  wire  [XLEN-1:0] b_i,
	output logic [XLEN-1:0] result_o
);

	logic less;

	assign less = $signed(a_i) < $signed(b_i);

	always_comb begin
		case (op_i)
			ALU_ADD: result_o = a_i + b_i;
			ALU_SUB: result_o = a_i - b_i;
			ALU_AND: result_o = a_i & b_i;
			ALU_OR:  result_o = a_i | b_i;
			ALU_XOR: result_o = a_i ^ b_i;
			ALU_SLT: result_o = {{(XLEN-1){1'b0}}, less};
			default: result_o = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/mult_pipe.sv
// Multiply path, product formed on entry and carried through the stages
`timescale 1ns/1ps
`default_nettype none

module mult_pipe
	import exe_pkg::*;
#(
	parameter int MULT_STAGES = 5
) (
	input  wire         clk_i,
	input  wire         arst_n_i,
	input  exe_ctrl_t   in_i,
	output mult_stage_t stages_o [1:MULT_STAGES]
);

	mult_stage_t entry;
	mult_stage_t stage_d [1:MULT_STAGES];

	// Low 32 bits only, same for signed and unsigned operands
	always_comb begin
		entry.valid = in_i.valid && in_i.mul && in_i.we;
		entry.rd    = in_i.rd;
		entry.value = in_i.op_a * in_i.op_b;
	end

	for (genvar s = 1; s <= MULT_STAGES; s++) begin : g_stage
		if (s == 1) begin : g_first
			assign stage_d[s] = entry;
		end else begin : g_next
			assign stage_d[s] = stages_o[s-1];
		end

		pipe_reg #(
			.payload_t (mult_stage_t)
		) u_stage (
			.clk_i    (clk_i),
			.arst_n_i (arst_n_i),
			.hold_i   (1'b0),
			.d_i      (stage_d[s]),
			.q_o      (stages_o[s])
		);
	end

endmodule

`default_nettype wire

//--- hw/bypass_ctrl.sv
// Operand forwarding and issue stall control
`timescale 1ns/1ps
`default_nettype none

module bypass_ctrl
	import exe_pkg::*;
#(
	parameter int MULT_STAGES = 5
) (
	input  reg_addr_t       rs1_i,
	input  reg_addr_t       rs2_i,
	input  reg_addr_t       rd_i,
	input  wire             uses_rs2_i,
	input  wire             is_mul_i,
	input  exe_ctrl_t       exe_i,
	input  wire  [XLEN-1:0] exe_result_i,
	input  mult_stage_t     mult_i [1:MULT_STAGES],
	input  retire_t         wb_i,
	input  wire  [XLEN-1:0] rf_data1_i,
	input  wire  [XLEN-1:0] rf_data2_i,
	output logic [XLEN-1:0] op_a_o,
	output logic [XLEN-1:0] op_b_o,
	output logic            stall_o
);

	logic            exe_alu_wr;
	logic            exe_mul_wr;
	logic            pending_hit;
	logic            wb_clash;
	reg_addr_t       src [2];
	logic [XLEN-1:0] rf_val [2];
	logic [XLEN-1:0] fwd_val [2];

	// True when a pending rd overlaps any register of the presented instruction
	function automatic logic touches(input reg_addr_t busy, input reg_addr_t a,
			input reg_addr_t b, input logic use_b, input reg_addr_t d);
		return (busy == a) || (use_b && busy == b) || (busy == d);
	endfunction

	assign exe_alu_wr = exe_i.valid && exe_i.we && !exe_i.mul;
	assign exe_mul_wr = exe_i.valid && exe_i.we && exe_i.mul;

	assign src[0]    = rs1_i;
	assign src[1]    = rs2_i;
	assign rf_val[0] = rf_data1_i;
	assign rf_val[1] = rf_data2_i;

	// Newest producer wins
	always_comb begin
		for (int i = 0; i < 2; i++) begin
			fwd_val[i] = rf_val[i];
			if (src[i] != '0) begin
				if (exe_alu_wr && exe_i.rd == src[i]) begin
					fwd_val[i] = exe_result_i;
				end else if (mult_i[MULT_STAGES].valid && mult_i[MULT_STAGES].rd == src[i]) begin
					fwd_val[i] = mult_i[MULT_STAGES].value;
				end else if (wb_i.valid && wb_i.rd == src[i]) begin
					fwd_val[i] = wb_i.data;
				end
			end
		end
	end

	assign op_a_o = fwd_val[0];
	assign op_b_o = fwd_val[1];

	// Products are not usable before the last stage
	always_comb begin
		pending_hit = exe_mul_wr && touches(exe_i.rd, rs1_i, rs2_i, uses_rs2_i, rd_i);
		for (int s = 1; s < MULT_STAGES; s++) begin
			if (mult_i[s].valid && touches(mult_i[s].rd, rs1_i, rs2_i, uses_rs2_i, rd_i)) begin
				pending_hit = 1'b1;
			end
		end
	end

	// A non-MUL issued now would reach writeback together with this product
	assign wb_clash = !is_mul_i && mult_i[MULT_STAGES-1].valid;

	assign stall_o = pending_hit || wb_clash;

endmodule

`default_nettype wire

//--- hw/exe_core.sv
// Execute back end top level with issue latch, multiply path and writeback
`timescale 1ns/1ps
`default_nettype none

module exe_core
	import exe_pkg::*;
#(
	parameter int MULT_STAGES = 5
) (
	input  wire     clk_i,
	input  wire     arst_n_i,
	input  issue_t  issue_i,
	output logic    issue_ready_o,
	output retire_t retire_o
);

	reg_addr_t       dec_rs1;
	reg_addr_t       dec_rs2;
	reg_addr_t       dec_rd;
	logic            dec_we;
	logic            dec_mul;
	logic            dec_use_imm;
	logic [XLEN-1:0] dec_imm;
	alu_op_e         dec_alu_op;
	logic            dec_uses_rs2;

	logic [XLEN-1:0] rf_data1;
	logic [XLEN-1:0] rf_data2;
	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] op_b;
	logic            stall;
	logic            accept;

	exe_ctrl_t       exe_d;
	exe_ctrl_t       exe_q;
	logic            exe_alu_wr;
	logic [XLEN-1:0] alu_result;
	mult_stage_t     mult_stages [1:MULT_STAGES];
	retire_t         wb_d;
	retire_t         wb_q;

	decoder u_decoder (
		.instr_i    (issue_i.instr),
		.rs1_o      (dec_rs1),
		.rs2_o      (dec_rs2),
		.rd_o       (dec_rd),
		.we_o       (dec_we),
		.mul_o      (dec_mul),
		.use_imm_o  (dec_use_imm),
		.imm_o      (dec_imm),
		.alu_op_o   (dec_alu_op),
		.uses_rs2_o (dec_uses_rs2)
	);

	int_registers u_int_registers (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.rs1_i    (dec_rs1),
		.rs2_i    (dec_rs2),
		.rd_i     (wb_q.rd),
		.we_i     (wb_q.valid),
		.wdata_i  (wb_q.data),
		.rdata1_o (rf_data1),
		.rdata2_o (rf_data2)
	);

	bypass_ctrl #(
		.MULT_STAGES (MULT_STAGES)
	) u_bypass_ctrl (
		.rs1_i        (dec_rs1),
		.rs2_i        (dec_rs2),
		.rd_i         (dec_rd),
		.uses_rs2_i   (dec_uses_rs2),
		.is_mul_i     (dec_mul),
		.exe_i        (exe_q),
		.exe_result_i (alu_result),
		.mult_i       (mult_stages),
		.wb_i         (wb_q),
		.rf_data1_i   (rf_data1),
		.rf_data2_i   (rf_data2),
		.op_a_o       (op_a),
		.op_b_o       (op_b),
		.stall_o      (stall)
	);

	assign issue_ready_o = !stall;
	assign accept        = issue_i.valid && !stall;

	// Bubble when nothing is accepted
	always_comb begin
		exe_d = '0;
		if (accept) begin
			exe_d.valid   = 1'b1;
			exe_d.rd      = dec_rd;
			exe_d.we      = dec_we;
			exe_d.mul     = dec_mul;
			exe_d.alu_op  = dec_alu_op;
			exe_d.op_a    = op_a;
			exe_d.op_b    = op_b;
			exe_d.imm     = dec_imm;
			exe_d.use_imm = dec_use_imm;
		end
	end

	pipe_reg #(
		.payload_t (exe_ctrl_t)
	) u_exe_latch (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.hold_i   (1'b0),
		.d_i      (exe_d),
		.q_o      (exe_q)
	);

	int_alu u_int_alu (
		.op_i     (exe_q.alu_op),
		.a_i      (exe_q.op_a),
		.b_i      (exe_q.use_imm ? exe_q.imm : exe_q.op_b),
		.result_o (alu_result)
	);

	mult_pipe #(
		.MULT_STAGES (MULT_STAGES)
	) u_mult_pipe (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.in_i     (exe_q),
		.stages_o (mult_stages)
	);

	assign exe_alu_wr = exe_q.valid && exe_q.we && !exe_q.mul;

	// Writeback merge, the issue stall keeps the two sources apart
	always_comb begin
		if (mult_stages[MULT_STAGES].valid) begin
			wb_d.valid = 1'b1;
			wb_d.rd    = mult_stages[MULT_STAGES].rd;
			wb_d.data  = mult_stages[MULT_STAGES].value;
		end else begin
			wb_d.valid = exe_alu_wr;
			wb_d.rd    = exe_q.rd;
			wb_d.data  = alu_result;
		end
	end

	pipe_reg #(
		.payload_t (retire_t)
	) u_wb_latch (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.hold_i   (1'b0),
		.d_i      (wb_d),
		.q_o      (wb_q)
	);

	assign retire_o = wb_q;

	a_single_writeback: assert property (
		@(posedge clk_i) disable iff (!arst_n_i)
		!(exe_alu_wr && mult_stages[MULT_STAGES].valid)
	);

endmodule

`default_nettype wire

//--- verification/exe_core_tb.sv
// Testbench for exe_core with a register reference model and directed tests
`timescale 1ns/1ps
`default_nettype none

module exe_core_tb
	import rv_isa_pkg::*;
	import exe_pkg::*;
();

	localparam int MULT_STAGES = 5;
	// 200 random issues stall at most about MULT_STAGES+1 cycles each, plus the directed tests
	localparam int MAX_CYCLES = 3000;

	localparam int K_ADD  = 0;
	localparam int K_SUB  = 1;
	localparam int K_AND  = 2;
	localparam int K_OR   = 3;
	localparam int K_XOR  = 4;
	localparam int K_SLT  = 5;
	localparam int K_ADDI = 6;
	localparam int K_ANDI = 7;
	localparam int K_ORI  = 8;
	localparam int K_XORI = 9;
	localparam int K_MUL  = 10;

	logic    clk_i;
	logic    arst_n_i;
	issue_t  issue_i;
	logic    issue_ready_o;
	retire_t retire_o;

	logic [31:0] model [32];
	retire_t     pend_q [$];
	int          retire_cycle [32];
	int          cycle = 0;
	int          errors;
	int          issued;
	int          retired;
	int          stall_cnt;
	int          tests_run;
	int          err_start;
	int          iss_start;
	int          ret_start;
	integer      seed;

	exe_core #(
		.MULT_STAGES (MULT_STAGES)
	) u_exe_core (
		.clk_i         (clk_i),
		.arst_n_i      (arst_n_i),
		.issue_i       (issue_i),
		.issue_ready_o (issue_ready_o),
		.retire_o      (retire_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i;
	end

	always @(posedge clk_i) begin
		cycle <= cycle + 1;
		if (cycle >= MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input reg_addr_t rs2,
			input reg_addr_t rs1, input logic [2:0] f3, input reg_addr_t rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input reg_addr_t rs1,
			input logic [2:0] f3, input reg_addr_t rd);
		return {imm, rs1, f3, rd, OPC_OP_IMM};
	endfunction

	// Match a retire record against the oldest pending write to its rd
	task automatic check_retire();
		int idx;
		idx = -1;
		if (arst_n_i && retire_o.valid) begin
			retired++;
			retire_cycle[retire_o.rd] = cycle;
			for (int i = 0; i < pend_q.size(); i++) begin
				if (idx < 0 && pend_q[i].rd == retire_o.rd) begin
					idx = i;
				end
			end
			if (idx < 0) begin
				$display("Unexpected retire to x%0d with no pending write", retire_o.rd);
				errors++;
			end else begin
				if (retire_o.data !== pend_q[idx].data) begin
					$display("ERR %0t: x%0d retired %h, expected %h", $time, retire_o.rd,
						retire_o.data, pend_q[idx].data);
					errors++;
				end
				pend_q.delete(idx);
			end
		end
	endtask

	// One cycle from just after a rising edge to just after the next one
	task automatic tick();
		@(negedge clk_i);
		check_retire();
		@(posedge clk_i);
		#1;
	endtask

	task automatic send_word(input logic [31:0] word);
		logic ready;
		issue_i.valid = 1'b1;
		issue_i.instr = word;
		ready = 1'b0;
		while (!ready) begin
			@(negedge clk_i);
			check_retire();
			ready = issue_ready_o;
			if (!ready) begin
				stall_cnt++;
			end
			@(posedge clk_i);
			#1;
		end
		issue_i.valid = 1'b0;
	endtask

	task automatic issue_op(input int kind, input reg_addr_t rd, input reg_addr_t rs1,
			input reg_addr_t rs2, input logic [11:0] imm);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] simm;
		logic [31:0] res;
		logic [31:0] word;
		retire_t     entry;
		a = model[rs1];
		b = model[rs2];
		simm = {{20{imm[11]}}, imm};
		case (kind)
			K_ADD:   word = enc_r(F7_BASE, rs2, rs1, F3_ADD, rd);
			K_SUB:   word = enc_r(F7_SUB, rs2, rs1, F3_ADD, rd);
			K_AND:   word = enc_r(F7_BASE, rs2, rs1, F3_AND, rd);
			K_OR:    word = enc_r(F7_BASE, rs2, rs1, F3_OR, rd);
			K_XOR:   word = enc_r(F7_BASE, rs2, rs1, F3_XOR, rd);
			K_SLT:   word = enc_r(F7_BASE, rs2, rs1, F3_SLT, rd);
			K_ADDI:  word = enc_i(imm, rs1, F3_ADD, rd);
			K_ANDI:  word = enc_i(imm, rs1, F3_AND, rd);
			K_ORI:   word = enc_i(imm, rs1, F3_OR, rd);
			K_XORI:  word = enc_i(imm, rs1, F3_XOR, rd);
			K_MUL:   word = enc_r(F7_MULDIV, rs2, rs1, F3_ADD, rd);
			default: word = '0;
		endcase
		case (kind)
			K_ADD:   res = a + b;
			K_SUB:   res = a - b;
			K_AND:   res = a & b;
			K_OR:    res = a | b;
			K_XOR:   res = a ^ b;
			K_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			K_ADDI:  res = a + simm;
			K_ANDI:  res = a & simm;
			K_ORI:   res = a | simm;
			K_XORI:  res = a ^ simm;
			K_MUL:   res = a * b;
			default: res = '0;
		endcase
		send_word(word);
		if (rd != '0) begin
			model[rd] = res;
			entry.valid = 1'b1;
			entry.rd = rd;
			entry.data = res;
			pend_q.push_back(entry);
			issued++;
		end
	endtask

	task automatic begin_test();
		err_start = errors;
		iss_start = issued;
		ret_start = retired;
		stall_cnt = 0;
	endtask

	// Drain the pipeline, then compare retire and issue counts of the test
	task automatic end_test(input string name);
		while (pend_q.size() != 0) begin
			tick();
		end
		repeat (8) tick();
		if (retired - ret_start != issued - iss_start) begin
			$display("Retire count mismatch in %s: %0d retired, %0d expected", name,
				retired - ret_start, issued - iss_start);
			errors++;
		end
		tests_run++;
		$display("Test %s: %s (%0d errors)", name, (errors == err_start) ? "ok" : "failed",
			errors - err_start);
	endtask

	task automatic test_reset();
		begin_test();
		for (int i = 0; i < 19; i++) begin
			@(negedge clk_i);
			if (retire_o.valid !== 1'b0 || issue_ready_o !== 1'b1) begin
				$display("ERR %0t: bad retire valid or issue ready around reset", $time);
				errors++;
			end
			@(posedge clk_i);
			#1;
			if (i == 15) begin
				arst_n_i = 1'b1;
			end
		end
		end_test("reset");
	endtask

	task automatic test_alu_chain();
		begin_test();
		issue_op(K_ADDI, 5'd1, 5'd0, 5'd0, 12'hEDD);
		issue_op(K_ADD, 5'd2, 5'd1, 5'd1, 12'h0);
		issue_op(K_SUB, 5'd3, 5'd1, 5'd2, 12'h0);
		issue_op(K_AND, 5'd4, 5'd3, 5'd2, 12'h0);
		issue_op(K_OR, 5'd5, 5'd4, 5'd1, 12'h0);
		issue_op(K_XOR, 5'd6, 5'd5, 5'd3, 12'h0);
		issue_op(K_SLT, 5'd7, 5'd6, 5'd5, 12'h0);
		if (stall_cnt != 0) begin
			$display("Issue ready dropped %0d times in the ALU chain", stall_cnt);
			errors++;
		end
		end_test("alu_chain");
	endtask

	task automatic test_mul_dependent();
		begin_test();
		issue_op(K_ADDI, 5'd8, 5'd0, 5'd0, 12'hFF9);
		issue_op(K_ADDI, 5'd9, 5'd0, 5'd0, 12'h7FF);
		issue_op(K_MUL, 5'd10, 5'd9, 5'd9, 12'h0);
		issue_op(K_ADD, 5'd14, 5'd10, 5'd8, 12'h0);
		issue_op(K_MUL, 5'd11, 5'd10, 5'd10, 12'h0);
		issue_op(K_MUL, 5'd12, 5'd11, 5'd8, 12'h0);
		issue_op(K_SUB, 5'd13, 5'd12, 5'd9, 12'h0);
		if (stall_cnt == 0) begin
			$display("Issue ready never dropped on a MUL dependency");
			errors++;
		end
		end_test("mul_dependent");
	endtask

	task automatic test_mul_independent();
		begin_test();
		issue_op(K_MUL, 5'd15, 5'd9, 5'd8, 12'h0);
		issue_op(K_ADD, 5'd16, 5'd1, 5'd2, 12'h0);
		issue_op(K_XOR, 5'd17, 5'd3, 5'd4, 12'h0);
		issue_op(K_OR, 5'd18, 5'd5, 5'd6, 12'h0);
		while (pend_q.size() != 0) begin
			tick();
		end
		for (int r = 16; r <= 18; r++) begin
			if (retire_cycle[15] <= retire_cycle[r]) begin
				$display("x%0d did not retire before the MUL product in x15", r);
				errors++;
			end
		end
		end_test("mul_independent");
	endtask

	task automatic test_x0_and_unsupported();
		begin_test();
		issue_op(K_ADDI, 5'd0, 5'd1, 5'd0, 12'h055);
		issue_op(K_ADD, 5'd0, 5'd1, 5'd2, 12'h0);
		issue_op(K_MUL, 5'd0, 5'd1, 5'd1, 12'h0);
		issue_op(K_ADD, 5'd19, 5'd0, 5'd0, 12'h0);
		issue_op(K_ADDI, 5'd20, 5'd0, 5'd0, 12'h000);
		// SLTI is outside the subset
		send_word(enc_i(12'h123, 5'd1, F3_SLT, 5'd21));
		send_word(32'h0000_0073);
		issue_op(K_ADD, 5'd22, 5'd21, 5'd0, 12'h0);
		end_test("x0_and_unsupported");
	endtask

	task automatic test_random_mix();
		logic [31:0] rnd;
		logic [31:0] rnd_imm;
		int          kind;
		begin_test();
		for (int n = 0; n < 200; n++) begin
			rnd = $random(seed);
			rnd_imm = $random(seed);
			kind = int'(rnd[7:0]) % 11;
			issue_op(kind, rnd[12:8], rnd[17:13], rnd[22:18], rnd_imm[11:0]);
		end
		end_test("random_mix");
	endtask

	initial begin
		arst_n_i = 1'b0;
		issue_i = '0;
		errors = 0;
		issued = 0;
		retired = 0;
		stall_cnt = 0;
		tests_run = 0;
		seed = 32'h7156;
		for (int i = 0; i < 32; i++) begin
			model[i] = '0;
			retire_cycle[i] = 0;
		end
		@(posedge clk_i);
		#1;
		test_reset();
		test_alu_chain();
		test_mul_dependent();
		test_mul_independent();
		test_x0_and_unsupported();
		test_random_mix();
		$display("Tests run: %0d, errors: %0d, retired: %0d, issued with rd: %0d",
			tests_run, errors, retired, issued);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
hw/rv_isa_pkg.sv
hw/exe_pkg.sv
hw/pipe_reg.sv
hw/decoder.sv
hw/int_registers.sv
hw/int_alu.sv
hw/mult_pipe.sv
hw/bypass_ctrl.sv
hw/exe_core.sv
verification/exe_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module exe_core_tb -f verilog.f -o exe_core_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out="$(./obj_dir/exe_core_sim)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "Simulation finished: PASS"; then
	exit 0
fi
exit 1
